// ==== rtl/bp_pkg.sv ====
`default_nettype none

package bp_pkg;

	// global history length
	parameter int HIST_BITS = 8;
	// pattern table address width, 256 counters
	parameter int PHT_INDEX_BITS = 8;
	parameter int PHT_ENTRIES = 1 << PHT_INDEX_BITS;
	parameter int PC_BITS = 32;
	// lowest pc bit that enters the hash
	parameter int PC_INDEX_LSB = 2;

	// queue depth used when the top level is not overridden, at most 16
	parameter int QUEUE_DEPTH_DEFAULT = 8;
	// tag covers the deepest allowed queue
	parameter int TAG_BITS = 4;
	// row counts run from 0 to 16
	parameter int COUNT_BITS = 5;

	// bit 0 is the newest outcome
	typedef logic [HIST_BITS-1:0] hist_t;
	typedef logic [PHT_INDEX_BITS-1:0] pht_index_t;
	typedef logic [PC_BITS-1:0] pc_t;
	// row number in the queue, oldest row is 0
	typedef logic [TAG_BITS-1:0] tag_t;
	typedef logic [COUNT_BITS-1:0] count_t;
	// 2-bit saturating counter, upper bit is the prediction
	typedef logic [1:0] counter_t;

	// weakly not taken
	parameter counter_t COUNTER_INIT = 2'b01;

endpackage

`default_nettype wire

// ==== rtl/pattern_table.sv ====
`timescale 1ns/100ps
`default_nettype none

module pattern_table (
	input wire logic clock,
	input wire logic reset,
	input wire bp_pkg::pht_index_t lookup_index,
	input wire logic update_valid,
	input wire bp_pkg::pht_index_t update_index,
	input wire logic update_taken,
	output bp_pkg::counter_t lookup_counter
);

	import bp_pkg::*;

	// one saturating counter per hashed index
	counter_t counters [PHT_ENTRIES];

	// counter being trained and its stepped value
	counter_t update_counter;
	counter_t next_counter;

	// move one step toward 11 on taken, toward 00 on not taken
	function automatic counter_t saturate_step(input counter_t value, input logic taken);
		counter_t result;
		result = value;
		if (taken) begin
			if (value != 2'b11) begin
				result = value + counter_t'(1);
			end
		end else begin
			if (value != 2'b00) begin
				result = value - counter_t'(1);
			end
		end
		return result;
	endfunction

	// read returns the value from before any update in this cycle
	assign lookup_counter = counters[lookup_index];

	assign update_counter = counters[update_index];
	assign next_counter = saturate_step(update_counter, update_taken);

	always_ff @(posedge clock) begin
		if (reset) begin
			// every branch starts weakly not taken
			for (int i = 0; i < PHT_ENTRIES; i++) begin
				counters[i] <= COUNTER_INIT;
			end
		end else if (update_valid) begin
			counters[update_index] <= next_counter;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/branch_history_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

module branch_history_queue #(
	parameter int QUEUE_DEPTH = bp_pkg::QUEUE_DEPTH_DEFAULT
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic append_valid,
	input wire bp_pkg::hist_t new_history,
	input wire bp_pkg::pht_index_t new_index,
	input wire logic resolve_valid,
	input wire logic resolve_mispredict,
	input wire bp_pkg::tag_t resolve_tag,
	input wire logic retire_valid,
	input wire bp_pkg::count_t retire_count,
	output bp_pkg::tag_t append_tag,
	output bp_pkg::hist_t spec_history,
	output logic queue_nonempty,
	output logic queue_full,
	output bp_pkg::pht_index_t resolve_index,
	output logic retired_valid,
	output bp_pkg::hist_t retired_history
);

	import bp_pkg::*;

	// row storage, row 0 holds the oldest branch in flight
	hist_t hist_rows [QUEUE_DEPTH];
	pht_index_t index_rows [QUEUE_DEPTH];
	// number of valid rows
	count_t tail;

	// row images after each step of the cycle
	hist_t cut_hist [QUEUE_DEPTH];
	hist_t shift_hist [QUEUE_DEPTH];
	hist_t next_hist [QUEUE_DEPTH];
	pht_index_t shift_index [QUEUE_DEPTH];
	pht_index_t next_index [QUEUE_DEPTH];
	count_t cut_tail;
	count_t shift_tail;
	count_t next_tail;

	logic mispredict;
	logic append_fits;
	logic append_take;

	assign queue_nonempty = (tail != '0);
	assign queue_full = (tail == count_t'(QUEUE_DEPTH));
	assign mispredict = resolve_valid && resolve_mispredict;
	// a zero-row retire changes nothing
	assign retired_valid = retire_valid && (retire_count != '0);
	// a full queue only takes a new row when rows leave in the same cycle
	assign append_fits = !queue_full || retired_valid;
	assign append_take = append_valid && append_fits;
	// new row lands behind the rows that survive recovery and retire
	assign append_tag = tag_t'(shift_tail);

	// read ports, all taken from the registered rows
	always_comb begin
		spec_history = '0;
		resolve_index = '0;
		retired_history = '0;
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			// newest row sits just below the tail
			if (count_t'(i + 1) == tail) begin
				spec_history = hist_rows[i];
			end
			if (tag_t'(i) == resolve_tag) begin
				resolve_index = index_rows[i];
			end
			// last row that leaves on retire
			if (count_t'(i + 1) == retire_count) begin
				retired_history = hist_rows[i];
			end
		end
	end

	// step 1, mispredict recovery
	always_comb begin
		cut_tail = tail;
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			cut_hist[i] = hist_rows[i];
			// resolving row recorded the wrong outcome as its newest bit
			if (mispredict && (tag_t'(i) == resolve_tag)) begin
				cut_hist[i][0] = ~hist_rows[i][0];
			end
		end
		// younger rows are dropped by pulling the tail back
		if (mispredict) begin
			cut_tail = count_t'(resolve_tag) + count_t'(1);
		end
	end

	// step 2, retire shifts the surviving rows down
	always_comb begin
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			shift_hist[i] = cut_hist[i];
			shift_index[i] = index_rows[i];
			if (retired_valid) begin
				for (int j = i; j < QUEUE_DEPTH; j++) begin
					if (count_t'(j - i) == retire_count) begin
						shift_hist[i] = cut_hist[j];
						shift_index[i] = index_rows[j];
					end
				end
			end
		end
		if (retired_valid) begin
			shift_tail = cut_tail - retire_count;
		end else begin
			shift_tail = cut_tail;
		end
	end

	// step 3, append at the adjusted tail
	always_comb begin
		next_tail = shift_tail;
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			next_hist[i] = shift_hist[i];
			next_index[i] = shift_index[i];
			if (append_take && (count_t'(i) == shift_tail)) begin
				next_hist[i] = new_history;
				next_index[i] = new_index;
			end
		end
		if (append_take) begin
			next_tail = shift_tail + count_t'(1);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			tail <= '0;
		end else begin
			tail <= next_tail;
		end
	end

	// rows past the tail are never read
	always_ff @(posedge clock) begin
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			hist_rows[i] <= next_hist[i];
			index_rows[i] <= next_index[i];
		end
	end

endmodule

`default_nettype wire

// ==== rtl/fetch_history.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_history (
	input wire logic clock,
	input wire logic reset,
	input wire logic lookup_valid,
	input wire bp_pkg::pc_t lookup_pc,
	input wire bp_pkg::counter_t lookup_counter,
	input wire logic queue_nonempty,
	input wire bp_pkg::hist_t spec_history,
	input wire bp_pkg::tag_t append_tag,
	input wire logic append_accepted,
	input wire logic retired_valid,
	input wire bp_pkg::hist_t retired_history,
	input wire logic resolve_valid,
	input wire logic resolve_mispredict,
	output bp_pkg::pht_index_t lookup_index,
	output logic append_valid,
	output bp_pkg::hist_t new_history,
	output bp_pkg::pht_index_t new_index,
	output logic predict_valid,
	output logic predict_taken,
	output bp_pkg::tag_t predict_tag
);

	import bp_pkg::*;

	// history of the last retired branch
	hist_t committed_history;

	// history the lookup is hashed with
	hist_t current_history;

	// pc slice that enters the hash, word aligned
	pht_index_t pc_slice;

	logic prediction;
	logic mispredict;

	assign mispredict = resolve_valid && resolve_mispredict;

	// in-flight branches carry the newest speculative history
	// an empty queue falls back to what has retired
	assign current_history = queue_nonempty ? spec_history : committed_history;

	// gshare hash
	assign pc_slice = lookup_pc[PC_INDEX_LSB +: PHT_INDEX_BITS];
	assign lookup_index = pc_slice ^ pht_index_t'(current_history);

	// upper counter bit is the direction
	assign prediction = lookup_counter[1];

	// new row records the history after this prediction
	assign new_history = {current_history[HIST_BITS-2:0], prediction};
	// stored so the resolve can train the same counter
	assign new_index = lookup_index;

	// fetch is being redirected on a mispredict, so the lookup is wrong-path
	assign append_valid = lookup_valid && !mispredict;

	always_ff @(posedge clock) begin
		if (reset) begin
			committed_history <= '0;
		end else if (retired_valid) begin
			committed_history <= retired_history;
		end
	end

	// prediction strobe follows the lookup by one cycle
	always_ff @(posedge clock) begin
		if (reset) begin
			predict_valid <= 1'b0;
		end else begin
			predict_valid <= append_valid && append_accepted;
		end
	end

	// direction and tag only move on an accepted append
	always_ff @(posedge clock) begin
		if (append_valid && append_accepted) begin
			predict_taken <= prediction;
			predict_tag <= append_tag;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/branch_predictor.sv ====
`timescale 1ns/100ps
`default_nettype none

module branch_predictor #(
	parameter int QUEUE_DEPTH = bp_pkg::QUEUE_DEPTH_DEFAULT
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic lookup_valid,
	input wire bp_pkg::pc_t lookup_pc,
	input wire logic resolve_valid,
	input wire bp_pkg::tag_t resolve_tag,
	input wire logic resolve_taken,
	input wire logic resolve_mispredict,
	input wire logic retire_valid,
	input wire bp_pkg::count_t retire_count,
	output logic predict_valid,
	output logic predict_taken,
	output bp_pkg::tag_t predict_tag,
	output logic queue_full
);

	import bp_pkg::*;

	// fetch side to queue and table
	pht_index_t lookup_index;
	counter_t lookup_counter;
	logic append_valid;
	hist_t new_history;
	pht_index_t new_index;

	// queue side back to fetch and table
	tag_t append_tag;
	hist_t spec_history;
	logic queue_nonempty;
	pht_index_t resolve_index;
	logic retired_valid;
	hist_t retired_history;

	// room exists unless full with nothing leaving, same rule as inside the queue
	logic append_accepted;
	assign append_accepted = !queue_full || retired_valid;

	fetch_history fetch_history_inst (
		.clock(clock),
		.reset(reset),
		.lookup_valid(lookup_valid),
		.lookup_pc(lookup_pc),
		.lookup_counter(lookup_counter),
		.queue_nonempty(queue_nonempty),
		.spec_history(spec_history),
		.append_tag(append_tag),
		.append_accepted(append_accepted),
		.retired_valid(retired_valid),
		.retired_history(retired_history),
		.resolve_valid(resolve_valid),
		.resolve_mispredict(resolve_mispredict),
		.lookup_index(lookup_index),
		.append_valid(append_valid),
		.new_history(new_history),
		.new_index(new_index),
		.predict_valid(predict_valid),
		.predict_taken(predict_taken),
		.predict_tag(predict_tag)
	);

	// every resolve trains, mispredicted or not
	pattern_table pattern_table_inst (
		.clock(clock),
		.reset(reset),
		.lookup_index(lookup_index),
		.update_valid(resolve_valid),
		.update_index(resolve_index),
		.update_taken(resolve_taken),
		.lookup_counter(lookup_counter)
	);

	branch_history_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) branch_history_queue_inst (
		.clock(clock),
		.reset(reset),
		.append_valid(append_valid),
		.new_history(new_history),
		.new_index(new_index),
		.resolve_valid(resolve_valid),
		.resolve_mispredict(resolve_mispredict),
		.resolve_tag(resolve_tag),
		.retire_valid(retire_valid),
		.retire_count(retire_count),
		.append_tag(append_tag),
		.spec_history(spec_history),
		.queue_nonempty(queue_nonempty),
		.queue_full(queue_full),
		.resolve_index(resolve_index),
		.retired_valid(retired_valid),
		.retired_history(retired_history)
	);

endmodule

`default_nettype wire

// ==== dv/branch_predictor_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module branch_predictor_tb;

	import bp_pkg::*;

	localparam int DEPTH = 8;
	// cycles a prediction may take to show up
	localparam int WAIT_LIMIT = 20;
	// expected column taken from the scoreboard model
	localparam int MODEL = -1;

	// one row of the stimulus table
	typedef struct packed {
		logic lookup;
		pc_t pc;
		logic rand_pc;
		logic resolve;
		tag_t rtag;
		logic rtaken;
		logic rmisp;
		logic retire;
		count_t rcount;
		int exp_taken;
		int exp_tag;
		int exp_full;
	} step_t;

	logic clock;
	logic reset;
	logic lookup_valid;
	pc_t lookup_pc;
	logic resolve_valid;
	tag_t resolve_tag;
	logic resolve_taken;
	logic resolve_mispredict;
	logic retire_valid;
	count_t retire_count;
	logic predict_valid;
	logic predict_taken;
	tag_t predict_tag;
	logic queue_full;

	step_t steps[$];
	string names[$];
	integer seed;
	int error_count;
	int test_count;
	int failed_tests;

	// scoreboard state with row 0 as the oldest branch
	hist_t model_hist [DEPTH];
	pht_index_t model_index [DEPTH];
	int model_tail;
	hist_t model_committed;
	counter_t model_counter [PHT_ENTRIES];

	branch_predictor #(
		.QUEUE_DEPTH(DEPTH)
	) branch_predictor_inst (
		.clock(clock),
		.reset(reset),
		.lookup_valid(lookup_valid),
		.lookup_pc(lookup_pc),
		.resolve_valid(resolve_valid),
		.resolve_tag(resolve_tag),
		.resolve_taken(resolve_taken),
		.resolve_mispredict(resolve_mispredict),
		.retire_valid(retire_valid),
		.retire_count(retire_count),
		.predict_valid(predict_valid),
		.predict_taken(predict_taken),
		.predict_tag(predict_tag),
		.queue_full(queue_full)
	);

	// 8 ns period
	always #4 clock = ~clock;

	function automatic void add_step(input string name, input int lookup, input pc_t pc,
			input int rand_pc, input int resolve, input int rtag, input int rtaken,
			input int rmisp, input int retire, input int rcount, input int exp_taken,
			input int exp_tag, input int exp_full);
		step_t s;
		s.lookup = (lookup != 0);
		s.pc = pc;
		s.rand_pc = (rand_pc != 0);
		s.resolve = (resolve != 0);
		s.rtag = tag_t'(rtag);
		s.rtaken = (rtaken != 0);
		s.rmisp = (rmisp != 0);
		s.retire = (retire != 0);
		s.rcount = count_t'(rcount);
		s.exp_taken = exp_taken;
		s.exp_tag = exp_tag;
		s.exp_full = exp_full;
		steps.push_back(s);
		names.push_back(name);
	endfunction

	// columns are name, lookup, pc, random pc, resolve, tag, taken, mispredict
	// then retire, count, expected taken, expected tag and expected full
	function automatic void build_table();
		// tags count up from an empty queue while all counters are weakly not taken
		add_step("first_lookup", 1, 32'h0000_0040, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		add_step("tag_one", 1, 32'h0000_0080, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0);
		add_step("tag_two", 1, 32'h0000_00c0, 0, 0, 0, 0, 0, 0, 0, 0, 2, 0);
		add_step("tag_three", 1, 32'h0000_0100, 0, 0, 0, 0, 0, 0, 0, 0, 3, 0);
		// two taken resolves push the counter of row 0 up to 11
		add_step("train_taken_a", 0, 32'h0, 0, 1, 0, 1, 0, 0, 0, MODEL, MODEL, 0);
		add_step("train_taken_b", 0, 32'h0, 0, 1, 0, 1, 0, 0, 0, MODEL, MODEL, 0);
		add_step("trained_hit", 1, 32'h0000_0040, 0, 0, 0, 0, 0, 0, 0, 1, 4, 0);
		// lookup in the mispredict cycle is wrong path
		add_step("mispredict_drop", 1, 32'h0000_0040, 0, 1, 4, 0, 1, 0, 0, MODEL, MODEL, 0);
		add_step("train_not_taken", 0, 32'h0, 0, 1, 4, 0, 0, 0, 0, MODEL, MODEL, 0);
		// flipped history of row 4 brings back the same index
		add_step("untrained_again", 1, 32'h0000_0040, 0, 0, 0, 0, 0, 0, 0, 0, 5, 0);
		add_step("retire_all_a", 0, 32'h0, 0, 0, 0, 0, 0, 1, 6, MODEL, MODEL, 0);
		// one pc back to back so each lookup hashes a shifted history
		add_step("spec_first", 1, 32'h0000_0200, 0, 0, 0, 0, 0, 0, 0, MODEL, 0, 0);
		add_step("spec_train", 0, 32'h0, 0, 1, 0, 1, 1, 0, 0, MODEL, MODEL, 0);
		add_step("spec_chain_a", 1, 32'h0000_0200, 0, 0, 0, 0, 0, 0, 0, MODEL, 1, 0);
		add_step("spec_chain_b", 1, 32'h0000_0200, 0, 0, 0, 0, 0, 0, 0, MODEL, 2, 0);
		add_step("spec_chain_c", 1, 32'h0000_0200, 0, 0, 0, 0, 0, 0, 0, MODEL, 3, 0);
		// cut back to 3 rows with the newest bit of row 2 flipped
		add_step("spec_recover", 0, 32'h0, 0, 1, 2, 1, 1, 0, 0, MODEL, MODEL, 0);
		add_step("spec_after_recover", 1, 32'h0000_0200, 0, 0, 0, 0, 0, 0, 0, MODEL, 3, 0);
		add_step("spec_random_a", 1, 32'h0, 1, 0, 0, 0, 0, 0, 0, MODEL, 4, 0);
		add_step("spec_random_b", 1, 32'h0, 1, 0, 0, 0, 0, 0, 0, MODEL, 5, 0);
		add_step("retire_all_b", 0, 32'h0, 0, 0, 0, 0, 0, 1, 6, MODEL, MODEL, 0);
		// fill to depth where the last one raises queue_full
		for (int i = 0; i < DEPTH; i++) begin
			add_step($sformatf("fill_%0d", i), 1, 32'h0000_0300 + pc_t'(i * 4), i % 2,
				0, 0, 0, 0, 0, 0, MODEL, i, (i == DEPTH - 1) ? 1 : 0);
		end
		add_step("full_drop", 1, 32'h0000_0340, 0, 0, 0, 0, 0, 0, 0, MODEL, MODEL, 1);
		add_step("retire_two_pass", 1, 32'h0000_0340, 0, 0, 0, 0, 0, 1, 2, MODEL, DEPTH - 2, 0);
		// newest row gets its last bit flipped so the retired history differs from reset
		add_step("flip_last", 0, 32'h0, 0, 1, DEPTH - 2, 1, 1, 0, 0, MODEL, MODEL, 0);
		add_step("retire_to_empty", 0, 32'h0, 0, 0, 0, 0, 0, 1, DEPTH - 1, MODEL, MODEL, 0);
		// empty queue hashes with the last retired history
		// a zero history would land on the counter trained taken by spec_train
		add_step("committed_history", 1, 32'h0000_0200, 0, 0, 0, 0, 0, 0, 0, MODEL, 0, 0);
	endfunction

	function automatic void reset_model();
		model_tail = 0;
		model_committed = '0;
		for (int i = 0; i < PHT_ENTRIES; i++) begin
			model_counter[i] = 2'b01;
		end
	endfunction

	// saturating 2-bit counter step
	function automatic counter_t step_counter(input counter_t value, input logic taken);
		if (taken && (value != 2'b11)) begin
			return value + 2'b01;
		end
		if (!taken && (value != 2'b00)) begin
			return value - 2'b01;
		end
		return value;
	endfunction

	// one cycle of the predictor rules in order resolve, mispredict cut, retire and append
	task automatic model_step(input step_t s, input pc_t pc, output logic pv, output logic pt,
			output tag_t ptag, output logic full);
		hist_t cur;
		pht_index_t idx;
		logic mispredict;
		logic leaving;
		logic room;
		int rt;
		int rc;
		rt = int'(s.rtag);
		rc = int'(s.rcount);
		cur = (model_tail != 0) ? model_hist[model_tail - 1] : model_committed;
		idx = pc[9:2] ^ cur;
		// lookup sees the counter from before this cycle's training
		pt = model_counter[idx][1];
		mispredict = s.resolve && s.rmisp;
		leaving = s.retire && (rc != 0);
		room = (model_tail != DEPTH) || leaving;
		if (s.resolve) begin
			model_counter[model_index[rt]] = step_counter(model_counter[model_index[rt]],
				s.rtaken);
		end
		if (mispredict) begin
			model_tail = rt + 1;
			model_hist[rt][0] = ~model_hist[rt][0];
		end
		if (leaving) begin
			model_committed = model_hist[rc - 1];
			for (int k = 0; k + rc < DEPTH; k++) begin
				model_hist[k] = model_hist[k + rc];
				model_index[k] = model_index[k + rc];
			end
			model_tail = model_tail - rc;
		end
		pv = s.lookup && !mispredict && room;
		ptag = tag_t'(model_tail);
		if (pv) begin
			model_hist[model_tail] = {cur[HIST_BITS-2:0], pt};
			model_index[model_tail] = idx;
			model_tail++;
		end
		full = (model_tail == DEPTH);
	endtask

	task automatic check_value(input string test, input string field, input int expected,
			input int actual);
		assert (expected == actual) else begin
			$display("FAIL %s %s expected %0d actual %0d", test, field, expected, actual);
			error_count++;
		end
	endtask

	task automatic finish_test(input string test, input int errors_before);
		test_count++;
		if (error_count == errors_before) begin
			$display("test %s: ok", test);
		end else begin
			failed_tests++;
			$display("test %s: %0d errors", test, error_count - errors_before);
		end
	endtask

	task automatic drive_idle();
		lookup_valid = 1'b0;
		lookup_pc = '0;
		resolve_valid = 1'b0;
		resolve_tag = '0;
		resolve_taken = 1'b0;
		resolve_mispredict = 1'b0;
		retire_valid = 1'b0;
		retire_count = '0;
	endtask

	// entered 1 ns after a rising edge and returns at the same point of a later cycle
	task automatic apply_step(input int n);
		step_t s;
		pc_t pc;
		logic exp_valid;
		logic exp_taken;
		tag_t exp_tag;
		logic exp_full;
		int waited;
		int errors_before;
		s = steps[n];
		errors_before = error_count;
		pc = s.rand_pc ? pc_t'($random(seed)) : s.pc;
		model_step(s, pc, exp_valid, exp_taken, exp_tag, exp_full);
		// table values override the model where given
		if (s.exp_taken != MODEL) begin
			exp_taken = (s.exp_taken != 0);
		end
		if (s.exp_tag != MODEL) begin
			exp_tag = tag_t'(s.exp_tag);
		end
		if (s.exp_full != MODEL) begin
			exp_full = (s.exp_full != 0);
		end
		lookup_valid = s.lookup;
		lookup_pc = pc;
		resolve_valid = s.resolve;
		resolve_tag = s.rtag;
		resolve_taken = s.rtaken;
		resolve_mispredict = s.rmisp;
		retire_valid = s.retire;
		retire_count = s.rcount;
		@(posedge clock);
		#1;
		// strobes last one cycle
		drive_idle();
		if (exp_valid) begin
			waited = 0;
			while (!predict_valid && (waited < WAIT_LIMIT)) begin
				@(posedge clock);
				#1;
				waited++;
			end
			assert (predict_valid) else begin
				$display("test %s: no prediction arrived within %0d cycles", names[n],
					WAIT_LIMIT);
				error_count++;
			end
			if (predict_valid) begin
				check_value(names[n], "predict_taken", int'(exp_taken), int'(predict_taken));
				check_value(names[n], "predict_tag", int'(exp_tag), int'(predict_tag));
			end
		end else begin
			check_value(names[n], "predict_valid", 0, int'(predict_valid));
		end
		check_value(names[n], "queue_full", int'(exp_full), int'(queue_full));
		finish_test(names[n], errors_before);
	endtask

	initial begin
		seed = 32'h5fd5_75d4;
		error_count = 0;
		test_count = 0;
		failed_tests = 0;
		clock = 1'b0;
		reset = 1'b1;
		drive_idle();
		reset_model();
		build_table();
		repeat (10) @(posedge clock);
		#1;
		reset = 1'b0;
		// idle predictor right out of reset
		check_value("after_reset", "queue_full", 0, int'(queue_full));
		check_value("after_reset", "predict_valid", 0, int'(predict_valid));
		finish_test("after_reset", 0);
		for (int n = 0; n < steps.size(); n++) begin
			apply_step(n);
		end
		$display("tests %0d, failed tests %0d, failed checks %0d", test_count, failed_tests,
			error_count);
		if (error_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
rtl/bp_pkg.sv
rtl/pattern_table.sv
rtl/branch_history_queue.sv
rtl/fetch_history.sv
rtl/branch_predictor.sv
dv/branch_predictor_tb.sv

// ==== Makefile ====
TOP = branch_predictor_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f build.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) > sim.log
	cat sim.log
	grep -q '^TB PASSED$$' sim.log

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module branch_predictor

clean:
	rm -rf obj_dir sim.log
